/* hdl/tft_pkg.sv */
// TFT player package with display opcodes, heading and drawer state types, and coordinate width.
package tft_pkg;

    // ------------------------------
    // Geometry
    // ------------------------------

    localparam int coord_w = 9;  // Covers columns and pages 0 to 319.

    // ------------------------------
    // Encodings
    // ------------------------------

    typedef enum logic [7:0] {
        cmd_caset = 8'h2a,  // Column address set.
        cmd_paset = 8'h2b,  // Page address set.
        cmd_ramwr = 8'h2c   // Memory write.
    } tft_cmd_e;

    typedef enum logic [1:0] {
        dir_right,
        dir_down,
        dir_left,
        dir_up
    } dir_e;

    typedef enum logic [1:0] {
        st_idle,
        st_window,
        st_pixels,
        st_next
    } draw_state_e;

endpackage

/* hdl/tft_byte_if.sv */
// Display byte link between the sprite drawer and the SPI transmitter.
`timescale 1ns/1ps

interface tft_byte_if;

    logic       transmit;  // One-cycle strobe.
    logic       dc;        // Low for a command, high for an argument or pixel.
    logic [7:0] data;
    logic       busy;

    modport master (
        output transmit,
        output dc,
        output data,
        input  busy
    );

    modport slave (
        input  transmit,
        input  dc,
        input  data,
        output busy
    );

endinterface

/* hdl/sprite_rotator.sv */
// Sprite rotator mapping a window pixel and a heading to a bitmap bit index.
`timescale 1ns/1ps

module sprite_rotator import tft_pkg::*; #(
    parameter int sprite_size = 22
) (
    input  logic [$clog2(sprite_size)-1:0]              col,
    input  logic [$clog2(sprite_size)-1:0]              row,
    input  dir_e                                        heading,
    output logic [$clog2(sprite_size*sprite_size)-1:0]  index
);

    localparam int cnt_w = $clog2(sprite_size);
    localparam int idx_w = $clog2(sprite_size * sprite_size);
    localparam logic [cnt_w-1:0] last = cnt_w'(sprite_size - 1);

    logic [cnt_w-1:0] src_col;
    logic [cnt_w-1:0] src_row;
    logic [idx_w-1:0] linear;

    always_comb begin
        src_col = col;  // Facing right is the stored orientation.
        src_row = row;
        case (heading)
            dir_left: src_col = last - col;
            dir_down: begin
                src_col = row;
                src_row = col;
            end
            dir_up: begin
                src_col = row;
                src_row = last - col;
            end
            default: ;
        endcase
    end

    // Row 0 sits in the most significant bits of the bitmap.
    assign linear = idx_w'(src_row) * idx_w'(sprite_size) + idx_w'(src_col);
    assign index  = idx_w'(sprite_size * sprite_size - 1) - linear;

endmodule

/* hdl/sprite_rom.sv */
// Sprite ROM holding the three mouth frames of the player bitmap.
`timescale 1ns/1ps

module sprite_rom #(
    parameter int sprite_size = 22
) (
    input  logic [1:0]                                  frame,
    input  logic [$clog2(sprite_size*sprite_size)-1:0]  index,
    output logic                                        lit
);

    localparam int bits = sprite_size * sprite_size;

    // Closed mouth, eye only.
    localparam logic [bits-1:0] frame_closed = {
        22'b0000000111111110000000,
        22'b0000011111111111100000,
        22'b0000111111111111110000,
        22'b0001111111111111111000,
        22'b0011111111111111111100,
        22'b0111111111110011111110,
        22'b0111111111110011111110,
        22'b1111111111111111111111,
        22'b1111111111111111111111,
        22'b1111111111111111111111,
        22'b1111111111111111111111,
        22'b1111111111111111111111,
        22'b1111111111111111111111,
        22'b1111111111111111111111,
        22'b1111111111111111111111,
        22'b0111111111111111111110,
        22'b0111111111111111111110,
        22'b0011111111111111111100,
        22'b0001111111111111111000,
        22'b0000111111111111110000,
        22'b0000011111111111100000,
        22'b0000000111111110000000
    };

    localparam logic [bits-1:0] frame_half = {
        22'b0000000111111110000000,
        22'b0000011111111111100000,
        22'b0000111111111111110000,
        22'b0001111111111111111000,
        22'b0011111111111111111100,
        22'b0111111111110011111110,
        22'b0111111111110011111110,
        22'b1111111111111111111110,
        22'b1111111111111111110000,
        22'b1111111111111110000000,
        22'b1111111111110000000000,
        22'b1111111111110000000000,
        22'b1111111111111110000000,
        22'b1111111111111111110000,
        22'b1111111111111111111110,
        22'b0111111111111111111110,
        22'b0111111111111111111110,
        22'b0011111111111111111100,
        22'b0001111111111111111000,
        22'b0000111111111111110000,
        22'b0000011111111111100000,
        22'b0000000111111110000000
    };

    localparam logic [bits-1:0] frame_wide = {
        22'b0000000111111110000000,
        22'b0000011111111111100000,
        22'b0000111111111111110000,
        22'b0001111111111111111000,
        22'b0011111111111111111100,
        22'b0111111111110011111100,
        22'b0111111111110011111000,
        22'b1111111111111111100000,
        22'b1111111111111110000000,
        22'b1111111111111000000000,
        22'b1111111111100000000000,
        22'b1111111111100000000000,
        22'b1111111111111000000000,
        22'b1111111111111110000000,
        22'b1111111111111111100000,
        22'b0111111111111111111000,
        22'b0111111111111111111100,
        22'b0011111111111111111100,
        22'b0001111111111111111000,
        22'b0000111111111111110000,
        22'b0000011111111111100000,
        22'b0000000111111110000000
    };

    always_comb begin
        case (frame)
            2'd0:    lit = frame_closed[index];
            2'd2:    lit = frame_wide[index];
            default: lit = frame_half[index];  // Frame 3 reuses the half-open mouth.
        endcase
    end

endmodule

/* hdl/player_drawer.sv */
// Player drawer that erases the uncovered old box and writes the rotated sprite window.
`timescale 1ns/1ps

module player_drawer import tft_pkg::*; #(
    parameter int sprite_size = 22
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            draw,
    input  logic [coord_w-1:0]              x,
    input  logic [coord_w-1:0]              y,
    input  dir_e                            direction,
    input  logic                            lit,
    output logic                            busy,
    output logic [$clog2(sprite_size)-1:0]  col,
    output logic [$clog2(sprite_size)-1:0]  row,
    output dir_e                            heading,
    output logic [1:0]                      frame,
    tft_byte_if.master                      tft
);

    localparam logic [coord_w-1:0] span = coord_w'(sprite_size - 1);
    localparam logic [coord_w-1:0] size = coord_w'(sprite_size);

    draw_state_e        state;
    logic [11:0]        draw_cnt;
    logic [coord_w-1:0] old_x;
    logic [coord_w-1:0] old_y;
    logic [coord_w-1:0] new_x;
    logic [coord_w-1:0] new_y;
    logic [coord_w-1:0] x_min;
    logic [coord_w-1:0] x_max;
    logic [coord_w-1:0] y_min;
    logic [coord_w-1:0] y_max;
    logic               erasing;
    logic [3:0]         step;
    logic [1:0]         sub;
    logic               can_send;
    logic [coord_w-1:0] dist_x;
    logic [coord_w-1:0] dist_y;
    logic               same_x;
    logic               same_y;
    logic               last_col;
    logic               last_row;
    logic [7:0]         win_byte;
    logic               win_dc;
    logic [7:0]         px_byte;

    function automatic logic [7:0] hi_byte(input logic [coord_w-1:0] v);
        return 8'(v >> 8);
    endfunction

    // ------------------------------
    // Window and pixel decode
    // ------------------------------

    assign can_send = !tft.busy && !tft.transmit;
    assign same_x   = (x == old_x);
    assign same_y   = (y == old_y);
    assign dist_x   = (x > old_x) ? x - old_x : old_x - x;
    assign dist_y   = (y > old_y) ? y - old_y : old_y - y;
    assign last_col = (coord_w'(col) == x_max - x_min);
    assign last_row = (coord_w'(row) == y_max - y_min);
    assign frame    = (draw_cnt[11:10] == 2'd3) ? 2'd1 : draw_cnt[11:10];

    assign win_dc  = !(step == 4'd0 || step == 4'd5 || step == 4'd10);
    assign px_byte = (erasing || !lit || sub == 2'd2) ? 8'h00 : 8'hff;  // Yellow is FF,FF,00.

    always_comb begin
        case (step)
            4'd0:    win_byte = cmd_caset;
            4'd1:    win_byte = hi_byte(x_min);
            4'd2:    win_byte = x_min[7:0];
            4'd3:    win_byte = hi_byte(x_max);
            4'd4:    win_byte = x_max[7:0];
            4'd5:    win_byte = cmd_paset;
            4'd6:    win_byte = hi_byte(y_min);
            4'd7:    win_byte = y_min[7:0];
            4'd8:    win_byte = hi_byte(y_max);
            4'd9:    win_byte = y_max[7:0];
            default: win_byte = cmd_ramwr;
        endcase
    end

    // ------------------------------
    // Sequencer
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            busy         <= 1'b0;
            tft.transmit <= 1'b0;
            draw_cnt     <= '0;
            old_x        <= coord_w'(5);
            old_y        <= coord_w'(5);
            erasing      <= 1'b0;
            step         <= '0;
            sub          <= '0;
            col          <= '0;
            row          <= '0;
        end else begin
            tft.transmit <= 1'b0;
            case (state)
                st_idle: begin
                    if (draw) begin
                        busy     <= 1'b1;
                        draw_cnt <= draw_cnt + 12'd1;
                        heading  <= direction;
                        new_x    <= x;
                        new_y    <= y;
                        step     <= '0;
                        erasing  <= !(same_x && same_y);
                        state    <= st_window;
                        x_min    <= old_x;  // Whole old box unless a strip is enough.
                        x_max    <= old_x + span;
                        y_min    <= old_y;
                        y_max    <= old_y + span;
                        if (same_x && !same_y && dist_y < size) begin
                            if (y > old_y) begin
                                y_max <= y - 1'b1;
                            end else begin
                                y_min <= y + size;
                            end
                        end else if (same_y && !same_x && dist_x < size) begin
                            if (x > old_x) begin
                                x_max <= x - 1'b1;
                            end else begin
                                x_min <= x + size;
                            end
                        end
                    end
                end
                st_window: begin
                    if (can_send) begin
                        tft.transmit <= 1'b1;
                        tft.dc       <= win_dc;
                        tft.data     <= win_byte;
                        if (step == 4'd10) begin
                            step  <= '0;
                            col   <= '0;
                            row   <= '0;
                            sub   <= '0;
                            state <= st_pixels;
                        end else begin
                            step <= step + 4'd1;
                        end
                    end
                end
                st_pixels: begin
                    if (can_send) begin
                        tft.transmit <= 1'b1;
                        tft.dc       <= 1'b1;
                        tft.data     <= px_byte;
                        if (sub == 2'd2) begin
                            sub <= '0;
                            if (last_col) begin
                                col <= '0;
                                if (last_row) begin
                                    state <= st_next;
                                end else begin
                                    row <= row + 1'b1;
                                end
                            end else begin
                                col <= col + 1'b1;
                            end
                        end else begin
                            sub <= sub + 2'd1;
                        end
                    end
                end
                st_next: begin
                    if (can_send) begin  // Last byte has left the transmitter.
                        if (erasing) begin
                            erasing <= 1'b0;
                            x_min   <= new_x;
                            x_max   <= new_x + span;
                            y_min   <= new_y;
                            y_max   <= new_y + span;
                            state   <= st_window;
                        end else begin
                            old_x <= new_x;
                            old_y <= new_y;
                            busy  <= 1'b0;
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* hdl/tft_spi_tx.sv */
// SPI transmitter sending one display byte MSB first with data/command select.
`timescale 1ns/1ps

module tft_spi_tx (
    input  logic       clk,
    input  logic       rst,
    tft_byte_if.slave  tft,
    output logic       spi_sclk,
    output logic       spi_mosi,
    output logic       spi_cs,
    output logic       tft_dc
);

    logic [7:0] shift_q;
    logic [2:0] bit_cnt;

    assign spi_mosi = shift_q[7];  // Moves only on the falling sclk edge.

    always_ff @(posedge clk) begin
        if (rst) begin
            tft.busy <= 1'b0;
            spi_cs   <= 1'b1;
            spi_sclk <= 1'b0;
            bit_cnt  <= '0;
        end else if (!tft.busy) begin
            if (tft.transmit) begin
                shift_q  <= tft.data;
                tft_dc   <= tft.dc;
                tft.busy <= 1'b1;
                spi_cs   <= 1'b0;
                spi_sclk <= 1'b0;
                bit_cnt  <= '0;
            end
        end else begin
            spi_sclk <= ~spi_sclk;
            if (spi_sclk) begin
                shift_q <= {shift_q[6:0], 1'b0};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin  // Eighth bit done, 16 cycles in all.
                    tft.busy <= 1'b0;
                    spi_cs   <= 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/player_display.sv */
// Player display top level joining the drawer, rotator, sprite ROM and SPI transmitter.
`timescale 1ns/1ps

module player_display import tft_pkg::*; #(
    parameter int sprite_size = 22
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               draw,
    input  logic [coord_w-1:0] x,
    input  logic [coord_w-1:0] y,
    input  dir_e               direction,
    output logic               busy,
    output logic               spi_sclk,
    output logic               spi_mosi,
    output logic               spi_cs,
    output logic               tft_dc
);

    logic [$clog2(sprite_size)-1:0]             col;
    logic [$clog2(sprite_size)-1:0]             row;
    dir_e                                       heading;
    logic [1:0]                                 frame;
    logic [$clog2(sprite_size*sprite_size)-1:0] index;
    logic                                       lit;

    tft_byte_if tft_bus ();

    player_drawer #(.sprite_size(sprite_size)) u_drawer (
        .clk(clk), .rst(rst), .draw(draw), .x(x), .y(y), .direction(direction),
        .lit(lit), .busy(busy), .col(col), .row(row), .heading(heading),
        .frame(frame), .tft(tft_bus.master)
    );

    sprite_rotator #(.sprite_size(sprite_size)) u_rotator (
        .col(col), .row(row), .heading(heading), .index(index)
    );

    sprite_rom #(.sprite_size(sprite_size)) u_rom (
        .frame(frame), .index(index), .lit(lit)
    );

    tft_spi_tx u_spi_tx (
        .clk(clk), .rst(rst), .tft(tft_bus.slave), .spi_sclk(spi_sclk),
        .spi_mosi(spi_mosi), .spi_cs(spi_cs), .tft_dc(tft_dc)
    );

endmodule

/* sim/tb_player_display.sv */
// Player display testbench decoding the SPI stream and comparing it with a byte-level model.
`timescale 1ns/1ps

module tb_player_display import tft_pkg::*;;

    localparam int sprite_size  = 22;
    localparam int n_draws      = 30;  // Ten directed requests and twenty random ones.
    localparam int window_bytes = 11 + 3 * sprite_size * sprite_size;
    localparam int draw_cycles  = 2 * window_bytes * 16;
    localparam int cycle_limit  = n_draws * draw_cycles + n_draws * draw_cycles / 4 + 2000;
    localparam int max_x        = 240 - sprite_size;
    localparam int max_y        = 320 - sprite_size;

    // Frame 0 of the sprite, row 0 first and column 0 in the leftmost bit.
    localparam logic [21:0] frame0 [22] = '{
        22'b0000000111111110000000, 22'b0000011111111111100000,
        22'b0000111111111111110000, 22'b0001111111111111111000,
        22'b0011111111111111111100, 22'b0111111111110011111110,
        22'b0111111111110011111110, 22'b1111111111111111111111,
        22'b1111111111111111111111, 22'b1111111111111111111111,
        22'b1111111111111111111111, 22'b1111111111111111111111,
        22'b1111111111111111111111, 22'b1111111111111111111111,
        22'b1111111111111111111111, 22'b0111111111111111111110,
        22'b0111111111111111111110, 22'b0011111111111111111100,
        22'b0001111111111111111000, 22'b0000111111111111110000,
        22'b0000011111111111100000, 22'b0000000111111110000000
    };

    logic               clk;
    logic               rst;
    logic               draw;
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    dir_e               direction;
    logic               busy;
    logic               spi_sclk;
    logic               spi_mosi;
    logic               spi_cs;
    logic               tft_dc;

    logic [8:0]  dec_q[$];  // Decoded bytes as {dc, data}.
    logic [8:0]  exp_q[$];
    logic [7:0]  shreg     = '0;
    int          nbits     = 0;
    int          byte_cnt  = 0;
    int          cycles    = 0;
    int          model_x   = 5;
    int          model_y   = 5;
    int          model_cnt = 0;
    logic [31:0] rnd       = 32'h2727;

    player_display #(.sprite_size(sprite_size)) u_dut (
        .clk(clk), .rst(rst), .draw(draw), .x(x), .y(y), .direction(direction),
        .busy(busy), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs(spi_cs),
        .tft_dc(tft_dc)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ------------------------------
    // Checks and model
    // ------------------------------

    task automatic fail_now();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
            fail_now();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic bit sprite_bit(input int c, input int r, input dir_e hd);
        int sc;
        int sr;
        sc = c;
        sr = r;
        case (hd)
            dir_left: sc = sprite_size - 1 - c;
            dir_down: begin
                sc = r;
                sr = c;
            end
            dir_up: begin
                sc = r;
                sr = sprite_size - 1 - c;
            end
            default: ;
        endcase
        return frame0[sr][sprite_size-1-sc];
    endfunction

    function automatic void push_window(input int x0, input int x1, input int y0,
                                        input int y1, input bit erase, input dir_e hd);
        bit on;
        exp_q.push_back({1'b0, 8'h2a});
        exp_q.push_back({1'b1, 8'(x0 >> 8)});
        exp_q.push_back({1'b1, 8'(x0)});
        exp_q.push_back({1'b1, 8'(x1 >> 8)});
        exp_q.push_back({1'b1, 8'(x1)});
        exp_q.push_back({1'b0, 8'h2b});
        exp_q.push_back({1'b1, 8'(y0 >> 8)});
        exp_q.push_back({1'b1, 8'(y0)});
        exp_q.push_back({1'b1, 8'(y1 >> 8)});
        exp_q.push_back({1'b1, 8'(y1)});
        exp_q.push_back({1'b0, 8'h2c});
        for (int r = 0; r <= y1 - y0; r++) begin
            for (int c = 0; c <= x1 - x0; c++) begin
                on = !erase && sprite_bit(c, r, hd);
                exp_q.push_back({1'b1, on ? 8'hff : 8'h00});  // Lit pixels are yellow.
                exp_q.push_back({1'b1, on ? 8'hff : 8'h00});
                exp_q.push_back({1'b1, 8'h00});
            end
        end
    endfunction

    function automatic void model_draw(input int nx, input int ny, input dir_e hd);
        int dx;
        int dy;
        int ox1;
        int oy1;
        dx  = nx - model_x;
        dy  = ny - model_y;
        ox1 = model_x + sprite_size - 1;
        oy1 = model_y + sprite_size - 1;
        model_cnt++;
        if (dx == 0 && dy > 0 && dy < sprite_size) begin
            push_window(model_x, ox1, model_y, ny - 1, 1'b1, hd);
        end else if (dx == 0 && dy < 0 && -dy < sprite_size) begin
            push_window(model_x, ox1, ny + sprite_size, oy1, 1'b1, hd);
        end else if (dy == 0 && dx > 0 && dx < sprite_size) begin
            push_window(model_x, nx - 1, model_y, oy1, 1'b1, hd);
        end else if (dy == 0 && dx < 0 && -dx < sprite_size) begin
            push_window(nx + sprite_size, ox1, model_y, oy1, 1'b1, hd);
        end else if (dx != 0 || dy != 0) begin
            push_window(model_x, ox1, model_y, oy1, 1'b1, hd);
        end
        push_window(nx, nx + sprite_size - 1, ny, ny + sprite_size - 1, 1'b0, hd);
        model_x = nx;
        model_y = ny;
    endfunction

    // ------------------------------
    // SPI decoder and compare
    // ------------------------------

    always @(posedge spi_sclk or posedge spi_cs) begin
        if (spi_cs) begin
            if (nbits == 8) begin
                dec_q.push_back({tft_dc, shreg});
            end else if (nbits != 0) begin
                $display("An SPI byte ended after %0d bits instead of 8.", nbits);
                fail_now();
            end
            nbits = 0;
        end else begin
            shreg = {shreg[6:0], spi_mosi};  // Panel samples on the rising sclk edge.
            nbits = nbits + 1;
        end
    end

    always @(posedge clk) begin
        logic [8:0] got;
        logic [8:0] want;
        while (dec_q.size() > 0) begin
            got = dec_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("Byte %h arrived on the SPI link with nothing expected.", got[7:0]);
                fail_now();
            end else begin
                want = exp_q.pop_front();
                check_value(32'(got), 32'(want), $sformatf("{dc, data} of byte %0d", byte_cnt));
                byte_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("The run exceeded its limit of %0d cycles.", cycle_limit);
            fail_now();
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic request(input int nx, input int ny, input dir_e hd, input bit poke);
        int waited;
        model_draw(nx, ny, hd);
        @(posedge clk);
        draw      <= 1'b1;
        x         <= coord_w'(nx);
        y         <= coord_w'(ny);
        direction <= hd;
        @(posedge clk);
        draw <= 1'b0;
        @(posedge clk);
        check_value(32'(busy), 32'd1, "busy after an accepted draw");
        if (poke) begin
            repeat (40) @(posedge clk);
            draw      <= 1'b1;  // Ignored while the drawer is busy.
            x         <= coord_w'(150);
            y         <= coord_w'(30);
            direction <= dir_up;
            @(posedge clk);
            draw <= 1'b0;
        end
        waited = 0;
        while (busy) begin
            @(posedge clk);
            waited++;
            if (waited > draw_cycles + draw_cycles / 4) begin
                $display("busy never fell after draw %0d at %0d,%0d.", model_cnt, nx, ny);
                fail_now();
            end
        end
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0 || dec_q.size() != 0) begin
            $display("Draw %0d at %0d,%0d ended with %0d bytes missing and %0d unexplained.",
                     model_cnt, nx, ny, exp_q.size(), dec_q.size());
            fail_now();
        end
    endtask

    initial begin
        int   nx;
        int   ny;
        int   sd;
        dir_e hd;
        rst       = 1'b1;
        draw      = 1'b0;
        x         = '0;
        y         = '0;
        direction = dir_right;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (20) @(posedge clk);
        check_value(32'(busy), 32'd0, "busy after reset");
        check_value(32'(spi_cs), 32'd1, "spi_cs after reset");
        check_value(32'(dec_q.size()), 32'd0, "bytes seen after reset");

        request(5, 5, dir_right, 1'b0);  // No erase at the reset position.
        request(6, 5, dir_right, 1'b0);
        request(6, 6, dir_down, 1'b0);
        request(5, 6, dir_left, 1'b0);
        request(5, 5, dir_up, 1'b0);
        request(100, 200, dir_right, 1'b0);
        request(100, 200, dir_down, 1'b0);
        request(100, 200, dir_left, 1'b1);
        request(100, 200, dir_up, 1'b0);
        request(100, 200, dir_right, 1'b0);

        for (int i = 0; i < 20; i++) begin
            rnd = xorshift(rnd);
            sd  = int'(rnd[7:4]) + 1;
            hd  = dir_e'(rnd[31:30]);
            nx  = model_x;
            ny  = model_y;
            case (rnd[1:0])
                2'd0: nx = (rnd[8] && nx + sd <= max_x) || nx - sd < 0 ? nx + sd : nx - sd;
                2'd1: ny = (rnd[8] && ny + sd <= max_y) || ny - sd < 0 ? ny + sd : ny - sd;
                default: begin
                    nx = int'(rnd[16:8]) % (max_x + 1);
                    ny = int'(rnd[25:17]) % (max_y + 1);
                end
            endcase
            request(nx, ny, hd, rnd[9]);
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* compile.f */
hdl/tft_pkg.sv
hdl/tft_byte_if.sv
hdl/sprite_rotator.sv
hdl/sprite_rom.sv
hdl/player_drawer.sv
hdl/tft_spi_tx.sv
hdl/player_display.sv
sim/tb_player_display.sv

/* run.sh */
#!/bin/sh
# Builds the player display testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f compile.f --top-module tb_player_display -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_player_display
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with failure status $status"
    exit "$status"
fi

exit 0
